/* Makefile */
# Verilator simulation of the arcade control and download front end

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"

obj_dir/Vfront_tb: list.f $(wildcard design/*.sv design/*.svh bench/*.sv)
	verilator --binary --timing -f list.f --top-module front_tb -Mdir obj_dir

# The run status is ignored here; the log search decides
test: obj_dir/Vfront_tb
	-./obj_dir/Vfront_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/front_tb.sv */
// Front end testbench

`timescale 1ns/1ps
`include "front_defs.svh"

module front_tb import front_pkg::*; ();

    localparam int CPU_COUNT = 8;

    typedef struct packed {
        logic      rnw;
        mem_be_t   be;
        mem_addr_t addr;
        mem_data_t din;
        mem_data_t dout;
        logic      cpu_req;
        mem_addr_t cpu_addr;
        mem_data_t cpu_din;
        mem_be_t   cpu_sel;
        logic      cpu_rdy;
        mem_data_t cpu_dout;
    } txn_t;

    logic                   CLK_32M;
    logic                   reset;
    logic [`PS2_KEY_W-1:0]  ps2_key;
    logic [`JOY_W-1:0]      joystick_0;
    logic [`JOY_W-1:0]      joystick_1;
    logic                   dl_active;
    logic [`DL_INDEX_W-1:0] dl_index;
    logic                   dl_wr;
    logic [`DL_ADDR_W-1:0]  dl_addr;
    dl_byte_t               dl_data;
    logic                   dl_wait;
    mem_addr_t              cpu_addr;
    mem_data_t              cpu_din;
    mem_be_t                cpu_wr_sel;
    logic                   cpu_req;
    mem_data_t              cpu_dout;
    logic                   cpu_rdy;
    mem_addr_t              mem_addr;
    mem_data_t              mem_din;
    mem_be_t                mem_be;
    logic                   mem_rnw;
    logic                   mem_req;
    mem_data_t              mem_dout;
    logic                   mem_rdy;
    logic [1:0]             coin;
    logic [1:0]             start_buttons;
    logic [3:0]             p1_joystick;
    logic [3:0]             p2_joystick;
    logic [3:0]             p1_buttons;
    logic [3:0]             p2_buttons;
    logic                   pause_button;
    logic [15:0]            dip_sw;

    integer    seed;
    txn_t      log_q[$];
    dl_byte_t  dl_bytes [64];
    int        dl_len;
    int        dl_words;
    int        rom_next = 0;
    int        cpu_checked = 0;
    mem_be_t   last_be = 2'b00;
    int        cpu_gap [CPU_COUNT];
    mem_data_t cpu_data [CPU_COUNT];
    mem_be_t   cpu_sel [CPU_COUNT];

    // Start 1, start 2, coin 1, coin 2, pause, up, down, left, right, A, B, X, Y
    logic [7:0] key_codes [13] = '{8'h16, 8'h1E, 8'h2E, 8'h36, 8'h4D, 8'h75, 8'h72,
                                   8'h6B, 8'h74, 8'h14, 8'h11, 8'h29, 8'h12};

    arcade_io_front UUT (.*);

    initial begin
        CLK_32M = 1'b0;
        forever #4 CLK_32M = ~CLK_32M;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // Be and data of ROM word k, a lone last byte goes alone
    function automatic logic [17:0] expected_word(input int k);
        if (2 * k + 1 < dl_len) begin
            return {2'b11, dl_bytes[2 * k + 1], dl_bytes[2 * k]};
        end
        return {2'b01, 8'h00, dl_bytes[2 * k]};
    endfunction

    // Inverted OR of keyboard and joysticks, keyboard shared by both players
    function automatic logic [20:0] expected_controls(input logic [12:0] held,
            input logic [15:0] j0, input logic [15:0] j1);
        logic [15:0] j;
        logic [3:0]  dir;
        logic [3:0]  btn;
        j   = j0 | j1;
        dir = {held[5], held[6], held[7], held[8]};
        btn = {held[9], held[10], held[11], held[12]};
        return {~{held[3], held[2] | j[9]}, ~{held[1] | j[10], held[0] | j[8]},
                ~(dir | j0[3:0]), ~(dir | j1[3:0]),
                ~(btn | {j0[4], j0[5], j0[6], j0[7]}),
                ~(btn | {j1[4], j1[5], j1[6], j1[7]}),
                ~(held[4] | j[11])};
    endfunction

    function automatic logic [20:0] control_word();
        return {coin, start_buttons, p1_joystick, p2_joystick,
                p1_buttons, p2_buttons, pause_button};
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        abort_run();
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_drive_slot();
        @(posedge CLK_32M);
        #1;
    endtask

    always @(negedge CLK_32M) begin
        if (dl_wr && dl_wait) begin
            $display("The download source strobed while dl_wait was high");
            abort_run();
        end
    end

    // Memory model, one random latency per request
    initial begin : memory_model
        int        wait_cycles;
        mem_data_t read_data;
        txn_t      t;
        mem_rdy  = 1'b0;
        mem_dout = '0;
        forever begin
            @(negedge CLK_32M);
            if (mem_req) begin
                wait_cycles = 1 + ($unsigned($random(seed)) % 6);
                read_data   = 16'($random(seed));
                repeat (wait_cycles) @(posedge CLK_32M);
                #1;
                mem_rdy  = 1'b1;
                mem_dout = read_data;
                @(negedge CLK_32M);
                t.rnw      = mem_rnw;
                t.be       = mem_be;
                t.addr     = mem_addr;
                t.din      = mem_din;
                t.dout     = mem_dout;
                t.cpu_req  = cpu_req;
                t.cpu_addr = cpu_addr;
                t.cpu_din  = cpu_din;
                t.cpu_sel  = cpu_wr_sel;
                t.cpu_rdy  = cpu_rdy;
                t.cpu_dout = cpu_dout;
                log_q.push_back(t);
                @(posedge CLK_32M);
                #1;
                mem_rdy = 1'b0;
            end
        end
    end

    // CPU addresses sit far above the ROM words, so a match is unambiguous
    always @(posedge CLK_32M) begin : compare_log
        txn_t        t;
        logic [17:0] exp;
        logic [15:0] mask;
        logic        cpu_match;
        while (log_q.size() != 0) begin
            t = log_q.pop_front();
            cpu_match = t.cpu_req && (t.addr == t.cpu_addr)
                        && (t.rnw == (t.cpu_sel == 2'b00))
                        && (t.rnw || (t.din == t.cpu_din && t.be == t.cpu_sel));
            if (cpu_match) begin
                check_value("cpu_rdy on a CPU transaction", 32'd1, 32'(t.cpu_rdy));
                check_value("cpu_dout", 32'(t.dout), 32'(t.cpu_dout));
                cpu_checked = cpu_checked + 1;
            end else begin
                if (rom_next >= dl_words) begin
                    $display("A memory transaction matched neither the CPU nor the loader");
                    abort_run();
                end
                exp  = expected_word(rom_next);
                mask = {{8{exp[17]}}, {8{exp[16]}}};
                check_value("ROM write address", 32'(rom_next), 32'(t.addr));
                check_value("ROM write direction", 32'd0, 32'(t.rnw));
                check_value("ROM byte enables", 32'(exp[17:16]), 32'(t.be));
                check_value("ROM write data", 32'(exp[15:0] & mask), 32'(t.din & mask));
                check_value("cpu_rdy during a ROM write", 32'd0, 32'(t.cpu_rdy));
                last_be  = t.be;
                rom_next = rom_next + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        @(negedge CLK_32M);
        check_value("controls after reset", 32'h001f_ffff, 32'(control_word()));
        check_value("dip_sw after reset", 32'hffff, 32'(dip_sw));
        check_value("mem_req after reset", 32'd0, 32'(mem_req));
        check_value("dl_wait after reset", 32'd0, 32'(dl_wait));
        check_value("cpu_rdy after reset", 32'd0, 32'(cpu_rdy));
        next_drive_slot();
    endtask

    task automatic settle_controls(input string name, input logic [20:0] exp);
        for (int c = 0; c < 6; c++) begin
            @(negedge CLK_32M);
            if (control_word() == exp) begin
                break;
            end
        end
        check_value(name, 32'(exp), 32'(control_word()));
        next_drive_slot();
    endtask

    task automatic key_merge_test();
        logic [12:0] held;
        logic        toggle;
        logic        pressed;
        held   = '0;
        toggle = 1'b0;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 13; k++) begin
                for (int ev = 0; ev < 2; ev++) begin
                    pressed = (ev == 0);
                    if (round == 1) begin
                        joystick_0 = 16'($random(seed));
                        joystick_1 = 16'($random(seed));
                    end
                    held[k] = pressed;
                    toggle  = ~toggle;
                    ps2_key = {toggle, pressed, 1'b0, key_codes[k]};
                    settle_controls($sformatf("key %02h event %0d round %0d",
                                    key_codes[k], ev, round),
                                    expected_controls(held, joystick_0, joystick_1));
                end
            end
        end
        joystick_0 = '0;
        joystick_1 = '0;
        settle_controls("all released", expected_controls(held, joystick_0, joystick_1));
    endtask

    task automatic strobe_download(input logic [7:0] index, input logic [24:0] addr,
            input dl_byte_t data);
        dl_index = index;
        dl_addr  = addr;
        dl_data  = data;
        dl_wr    = 1'b1;
        next_drive_slot();
        dl_wr    = 1'b0;
        next_drive_slot();
    endtask

    task automatic dip_capture_test();
        dl_byte_t dip_ref [`DIP_BANKS];
        for (int a = 0; a < `DIP_BANKS; a++) begin
            dip_ref[a] = 8'($random(seed));
            strobe_download(8'(`DL_INDEX_DIP), 25'(a), dip_ref[a]);
        end
        @(negedge CLK_32M);
        check_value("dip capture", 32'({~dip_ref[1], ~dip_ref[0]}), 32'(dip_sw));
        next_drive_slot();
        // Wrong index or an address past the bank
        strobe_download(8'd1, 25'd0, 8'hA5);
        strobe_download(8'd253, 25'd1, 8'h5A);
        strobe_download(8'(`DL_INDEX_DIP), 25'd8, 8'hC3);
        strobe_download(8'(`DL_INDEX_DIP), 25'd9, 8'h3C);
        strobe_download(8'(`DL_INDEX_DIP), 25'h100_0000, 8'h77);
        @(negedge CLK_32M);
        check_value("dip ignored strobes", 32'({~dip_ref[1], ~dip_ref[0]}), 32'(dip_sw));
        next_drive_slot();
    endtask

    task automatic drive_rom_stream();
        int guard;
        for (int i = 0; i < dl_len; i++) begin
            guard = 0;
            while (dl_wait) begin
                if (guard == 200) begin
                    timeout_fail("dl_wait to fall during the ROM download");
                end
                guard++;
                next_drive_slot();
            end
            dl_addr = 25'(i);
            dl_data = dl_bytes[i];
            dl_wr   = 1'b1;
            next_drive_slot();
            dl_wr   = 1'b0;
            if (i == dl_len - 1) begin
                dl_active = 1'b0;
            end
            next_drive_slot();
        end
    endtask

    task automatic issue_cpu_accesses();
        int guard;
        for (int n = 0; n < CPU_COUNT; n++) begin
            repeat (cpu_gap[n]) next_drive_slot();
            cpu_addr   = mem_addr_t'(32'h0080_0000 + n * 16);
            cpu_din    = cpu_data[n];
            cpu_wr_sel = cpu_sel[n];
            cpu_req    = 1'b1;
            guard = 0;
            @(negedge CLK_32M);
            while (!cpu_rdy) begin
                if (guard == 300) begin
                    timeout_fail("cpu_rdy during the ROM download");
                end
                guard++;
                @(negedge CLK_32M);
            end
            next_drive_slot();
            cpu_req = 1'b0;
        end
    endtask

    task automatic rom_download_test();
        int guard;
        dl_len   = 21 + 2 * ($unsigned($random(seed)) % 10);
        dl_words = (dl_len + 1) / 2;
        for (int i = 0; i < dl_len; i++) begin
            dl_bytes[i] = 8'($random(seed));
        end
        // First access a read, second a full write
        for (int n = 0; n < CPU_COUNT; n++) begin
            cpu_gap[n]  = 1 + ($unsigned($random(seed)) % 4);
            cpu_data[n] = 16'($random(seed));
            cpu_sel[n]  = (n == 0) ? 2'b00 : (n == 1) ? 2'b11 : 2'($random(seed));
        end
        dl_index  = 8'(`DL_INDEX_ROM);
        dl_active = 1'b1;
        next_drive_slot();
        fork
            drive_rom_stream();
            issue_cpu_accesses();
        join
        guard = 0;
        while (rom_next != dl_words || cpu_checked != CPU_COUNT) begin
            if (guard == 2000) begin
                timeout_fail("every ROM word and CPU access to be logged");
            end
            guard++;
            next_drive_slot();
        end
        check_value("final ROM byte enables", 32'b01, 32'(last_be));
        check_value("dl_wait after download", 32'd0, 32'(dl_wait));
    endtask

    initial begin
        seed       = 32'h2e43_1a1a;
        reset      = 1'b1;
        ps2_key    = '0;
        joystick_0 = '0;
        joystick_1 = '0;
        dl_active  = 1'b0;
        dl_index   = '0;
        dl_wr      = 1'b0;
        dl_addr    = '0;
        dl_data    = '0;
        cpu_addr   = '0;
        cpu_din    = '0;
        cpu_wr_sel = '0;
        cpu_req    = 1'b0;
        repeat (2) @(posedge CLK_32M);
        #1;
        reset = 1'b0;

        check_reset_state();
        key_merge_test();
        dip_capture_test();
        rom_download_test();

        $display("Regression passed");
        $finish;
    end

endmodule

/* design/arcade_io_front.sv */
// Arcade control and download front end

`timescale 1ns/1ps
`include "front_defs.svh"

module arcade_io_front import front_pkg::*; (
    input  logic                   CLK_32M,
    input  logic                   reset,
    input  logic [`PS2_KEY_W-1:0]  ps2_key,
    input  logic [`JOY_W-1:0]      joystick_0,
    input  logic [`JOY_W-1:0]      joystick_1,

    // Download stream
    input  logic                   dl_active,
    input  logic [`DL_INDEX_W-1:0] dl_index,
    input  logic                   dl_wr,
    input  logic [`DL_ADDR_W-1:0]  dl_addr,
    input  dl_byte_t               dl_data,
    output logic                   dl_wait,

    // CPU side of the shared channel
    input  mem_addr_t              cpu_addr,
    input  mem_data_t              cpu_din,
    input  mem_be_t                cpu_wr_sel,
    input  logic                   cpu_req,
    output mem_data_t              cpu_dout,
    output logic                   cpu_rdy,

    // Memory channel
    output mem_addr_t              mem_addr,
    output mem_data_t              mem_din,
    output mem_be_t                mem_be,
    output logic                   mem_rnw,
    output logic                   mem_req,
    input  mem_data_t              mem_dout,
    input  logic                   mem_rdy,

    // Active-low controls
    output logic [1:0]             coin,
    output logic [1:0]             start_buttons,
    output logic [3:0]             p1_joystick,
    output logic [3:0]             p2_joystick,
    output logic [3:0]             p1_buttons,
    output logic [3:0]             p2_buttons,
    output logic                   pause_button,
    output logic [15:0]            dip_sw
);

    mem_req_if loader_bus ();
    mem_req_if cpu_bus ();
    mem_req_if mem_bus ();

    mem_addr_t rom_addr;
    logic      rom_clear;
    logic      rom_advance;

    // A CPU access with no byte selected is a read
    assign cpu_bus.addr = cpu_addr;
    assign cpu_bus.din  = cpu_din;
    assign cpu_bus.be   = cpu_wr_sel;
    assign cpu_bus.rnw  = ~|cpu_wr_sel;
    assign cpu_bus.req  = cpu_req;
    assign cpu_dout     = cpu_bus.dout;
    assign cpu_rdy      = cpu_bus.rdy;

    assign mem_addr     = mem_bus.addr;
    assign mem_din      = mem_bus.din;
    assign mem_be       = mem_bus.be;
    assign mem_rnw      = mem_bus.rnw;
    assign mem_req      = mem_bus.req;
    assign mem_bus.dout = mem_dout;
    assign mem_bus.rdy  = mem_rdy;

    player_input_map u_input (
        .CLK_32M(CLK_32M), .reset(reset), .ps2_key(ps2_key),
        .joystick_0(joystick_0), .joystick_1(joystick_1),
        .coin(coin), .start_buttons(start_buttons),
        .p1_joystick(p1_joystick), .p2_joystick(p2_joystick),
        .p1_buttons(p1_buttons), .p2_buttons(p2_buttons),
        .pause_button(pause_button)
    );

    dip_switch_bank u_dip (
        .CLK_32M(CLK_32M), .reset(reset), .dl_wr(dl_wr), .dl_index(dl_index),
        .dl_addr(dl_addr), .dl_data(dl_data), .dip_sw(dip_sw)
    );

    rom_word_counter u_counter (
        .CLK_32M(CLK_32M), .reset(reset), .clear(rom_clear),
        .advance(rom_advance), .word_addr(rom_addr)
    );

    rom_write_fsm u_rom_fsm (
        .CLK_32M(CLK_32M), .reset(reset), .dl_active(dl_active),
        .dl_index(dl_index), .dl_wr(dl_wr), .dl_data(dl_data),
        .dl_wait(dl_wait), .word_addr(rom_addr), .clear(rom_clear),
        .advance(rom_advance), .mem(loader_bus)
    );

    mem_channel_mux u_mux (
        .CLK_32M(CLK_32M), .reset(reset), .loader(loader_bus),
        .cpu(cpu_bus), .mem(mem_bus)
    );

endmodule

/* design/dip_switch_bank.sv */
// DIP switch capture

`timescale 1ns/1ps
`include "front_defs.svh"

module dip_switch_bank import front_pkg::*; (
    input  logic                   CLK_32M,
    input  logic                   reset,
    input  logic                   dl_wr,
    input  logic [`DL_INDEX_W-1:0] dl_index,
    input  logic [`DL_ADDR_W-1:0]  dl_addr,
    input  dl_byte_t               dl_data,
    output logic [15:0]            dip_sw
);

    localparam int SEL_W = $clog2(`DIP_BANKS);

    dl_byte_t   dip_bytes [`DIP_BANKS];
    logic       dip_wr;
    logic [SEL_W-1:0] dip_sel;

    // Only the low addresses of the DIP index hold switch bytes
    assign dip_wr  = dl_wr && (dl_index == `DL_INDEX_W'(`DL_INDEX_DIP))
                     && (dl_addr < `DL_ADDR_W'(`DIP_BANKS));
    assign dip_sel = dl_addr[SEL_W-1:0];

    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            for (int i = 0; i < `DIP_BANKS; i++) begin
                dip_bytes[i] <= '0;
            end
        end else if (dip_wr) begin
            dip_bytes[dip_sel] <= dl_data;
        end
    end

    // Switches are stored active high and presented active low
    assign dip_sw = ~{dip_bytes[1], dip_bytes[0]};

endmodule

/* design/front_defs.svh */
// Front end widths and download constants

`ifndef FRONT_DEFS_SVH
`define FRONT_DEFS_SVH

// Word address of the 16-bit memory channel
`define MEM_ADDR_W 24

// Download byte stream from the host
`define DL_ADDR_W 25
`define DL_INDEX_W 8
`define DL_DATA_W 8

// Download index values
`define DL_INDEX_ROM 0
`define DL_INDEX_DIP 254

// Number of stored DIP switch bytes
`define DIP_BANKS 8

// Player input words
`define PS2_KEY_W 11
`define JOY_W 16

`endif

/* design/front_pkg.sv */
// Front end shared types

package front_pkg;

`include "front_defs.svh"

    // Memory channel fields
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [1:0] mem_be_t;

    // One byte of the download stream
    typedef logic [`DL_DATA_W-1:0] dl_byte_t;

    // ROM write sequencer
    typedef enum logic [1:0] {
        st_empty,
        st_half,
        st_busy
    } rom_state_e;

    // PS/2 set 2 scan codes in use
    typedef enum logic [7:0] {
        key_start1 = 8'h16,
        key_start2 = 8'h1E,
        key_coin1  = 8'h2E,
        key_coin2  = 8'h36,
        key_pause  = 8'h4D,
        key_up     = 8'h75,
        key_down   = 8'h72,
        key_left   = 8'h6B,
        key_right  = 8'h74,
        key_a      = 8'h14,
        key_b      = 8'h11,
        key_x      = 8'h29,
        key_y      = 8'h12
    } key_code_e;

    // Current holder of the shared memory channel
    typedef enum logic [1:0] {
        own_none,
        own_loader,
        own_cpu
    } mem_owner_e;

endpackage

/* design/mem_channel_mux.sv */
// Shared memory channel arbiter

`timescale 1ns/1ps

module mem_channel_mux import front_pkg::*; (
    input  logic         CLK_32M,
    input  logic         reset,
    mem_req_if.channel   loader,
    mem_req_if.channel   cpu,
    mem_req_if.requester mem
);

    mem_owner_e owner;
    mem_owner_e cur_owner;

    // Grant in the cycle the request is seen, loader first on a tie
    always_comb begin
        if (owner != own_none) begin
            cur_owner = owner;
        end else if (loader.req) begin
            cur_owner = own_loader;
        end else if (cpu.req) begin
            cur_owner = own_cpu;
        end else begin
            cur_owner = own_none;
        end
    end

    // Ownership is released by the ready pulse
    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            owner <= own_none;
        end else if (mem.rdy) begin
            owner <= own_none;
        end else begin
            owner <= cur_owner;
        end
    end

    always_comb begin
        mem.addr = '0;
        mem.din  = '0;
        mem.be   = '0;
        mem.rnw  = 1'b1;
        mem.req  = 1'b0;
        case (cur_owner)
            own_loader: begin
                mem.addr = loader.addr;
                mem.din  = loader.din;
                mem.be   = loader.be;
                mem.rnw  = loader.rnw;
                mem.req  = loader.req;
            end
            own_cpu: begin
                mem.addr = cpu.addr;
                mem.din  = cpu.din;
                mem.be   = cpu.be;
                mem.rnw  = cpu.rnw;
                mem.req  = cpu.req;
            end
            default: ;
        endcase
    end

    // Return path to the owner only
    assign loader.rdy  = mem.rdy && (cur_owner == own_loader);
    assign loader.dout = (cur_owner == own_loader) ? mem.dout : '0;
    assign cpu.rdy     = mem.rdy && (cur_owner == own_cpu);
    assign cpu.dout    = (cur_owner == own_cpu) ? mem.dout : '0;

endmodule

/* design/mem_req_if.sv */
// Memory channel request interface

`timescale 1ns/1ps

interface mem_req_if import front_pkg::*; ();

    mem_addr_t addr;
    mem_data_t din;
    mem_be_t   be;
    logic      rnw;
    logic      req;
    logic      rdy;
    mem_data_t dout;

    // Requester holds req with stable fields until rdy
    modport requester (
        output addr, din, be, rnw, req,
        input  rdy, dout
    );

    modport channel (
        input  addr, din, be, rnw, req,
        output rdy, dout
    );

endinterface

/* design/player_input_map.sv */
// Keyboard and joystick control mapping

`timescale 1ns/1ps
`include "front_defs.svh"

module player_input_map import front_pkg::*; (
    input  logic                  CLK_32M,
    input  logic                  reset,
    input  logic [`PS2_KEY_W-1:0] ps2_key,
    input  logic [`JOY_W-1:0]     joystick_0,
    input  logic [`JOY_W-1:0]     joystick_1,
    output logic [1:0]            coin,
    output logic [1:0]            start_buttons,
    output logic [3:0]            p1_joystick,
    output logic [3:0]            p2_joystick,
    output logic [3:0]            p1_buttons,
    output logic [3:0]            p2_buttons,
    output logic                  pause_button
);

    logic [`PS2_KEY_W-1:0] key_q;
    logic                  toggle_q;
    key_code_e             key_code;
    logic                  pressed;
    logic [3:0]            kb_dir;
    logic [3:0]            kb_btn;
    logic                  kb_start1, kb_start2, kb_coin1, kb_coin2, kb_pause;
    logic [`JOY_W-1:0]     joy;

    assign key_code = key_code_e'(key_q[7:0]);
    assign pressed  = key_q[9];

    // Key events are registered once, then the toggle bit is compared
    always_ff @(posedge CLK_32M) begin
        key_q <= ps2_key;
        if (reset) begin
            toggle_q  <= ps2_key[10];
            kb_dir    <= 4'b0000;
            kb_btn    <= 4'b0000;
            kb_start1 <= 1'b0;
            kb_start2 <= 1'b0;
            kb_coin1  <= 1'b0;
            kb_coin2  <= 1'b0;
            kb_pause  <= 1'b0;
        end else begin
            toggle_q <= key_q[10];
            if (toggle_q != key_q[10]) begin
                case (key_code)
                    key_start1: kb_start1 <= pressed;
                    key_start2: kb_start2 <= pressed;
                    key_coin1:  kb_coin1  <= pressed;
                    key_coin2:  kb_coin2  <= pressed;
                    key_pause:  kb_pause  <= pressed;
                    key_up:     kb_dir[3] <= pressed;
                    key_down:   kb_dir[2] <= pressed;
                    key_left:   kb_dir[1] <= pressed;
                    key_right:  kb_dir[0] <= pressed;
                    key_a:      kb_btn[3] <= pressed;
                    key_b:      kb_btn[2] <= pressed;
                    key_x:      kb_btn[1] <= pressed;
                    key_y:      kb_btn[0] <= pressed;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Active-low merge with the joysticks
    ////////////////////////////////////////////////////////////////////////////

    assign joy = joystick_0 | joystick_1;

    // Keyboard directions and buttons are shared by both players
    assign p1_joystick = ~(kb_dir | joystick_0[3:0]);
    assign p2_joystick = ~(kb_dir | joystick_1[3:0]);
    assign p1_buttons  = ~(kb_btn | {joystick_0[4], joystick_0[5], joystick_0[6], joystick_0[7]});
    assign p2_buttons  = ~(kb_btn | {joystick_1[4], joystick_1[5], joystick_1[6], joystick_1[7]});

    // Coin 2 has no joystick bit
    assign start_buttons = ~{kb_start2 | joy[10], kb_start1 | joy[8]};
    assign coin          = ~{kb_coin2, kb_coin1 | joy[9]};
    assign pause_button  = ~(kb_pause | joy[11]);

endmodule

/* design/rom_word_counter.sv */
// ROM word address counter

`timescale 1ns/1ps

module rom_word_counter import front_pkg::*; (
    input  logic      CLK_32M,
    input  logic      reset,
    input  logic      clear,
    input  logic      advance,
    output mem_addr_t word_addr
);

    mem_addr_t count;

    // Clear wins over advance at download start
    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (advance) begin
            count <= count + 1'b1;
        end
    end

    assign word_addr = count;

endmodule

/* design/rom_write_fsm.sv */
// ROM download write sequencer

`timescale 1ns/1ps
`include "front_defs.svh"

module rom_write_fsm import front_pkg::*; (
    input  logic                   CLK_32M,
    input  logic                   reset,
    input  logic                   dl_active,
    input  logic [`DL_INDEX_W-1:0] dl_index,
    input  logic                   dl_wr,
    input  dl_byte_t               dl_data,
    output logic                   dl_wait,
    input  mem_addr_t              word_addr,
    output logic                   clear,
    output logic                   advance,
    mem_req_if.requester           mem
);

    rom_state_e state;
    logic       rom_sel;
    logic       rom_wr;
    logic       active_q;
    dl_byte_t   low_byte;
    mem_data_t  word_data;
    mem_be_t    word_be;

    assign rom_sel = (dl_index == `DL_INDEX_W'(`DL_INDEX_ROM));
    assign rom_wr  = dl_wr && rom_sel;

    // Rising edge of a ROM download restarts the word address
    assign clear = dl_active && rom_sel && !active_q;

    // Counter moves on the same edge that leaves st_busy
    assign advance = (state == st_busy) && mem.rdy;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_32M) begin
        if (reset) begin
            state    <= st_empty;
            active_q <= 1'b0;
        end else begin
            active_q <= dl_active && rom_sel;
            case (state)
                st_empty: begin
                    if (rom_wr) begin
                        state <= st_half;
                    end
                end
                st_half: begin
                    // A lone byte at the end is flushed by itself
                    if (rom_wr || !dl_active) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (mem.rdy) begin
                        state <= st_empty;
                    end
                end
                default: state <= st_empty;
            endcase
        end
    end

    // Byte pairing
    always_ff @(posedge CLK_32M) begin
        if (state == st_empty && rom_wr) begin
            low_byte <= dl_data;
        end
        if (state == st_half) begin
            if (rom_wr) begin
                word_data <= {dl_data, low_byte};
                word_be   <= 2'b11;
            end else if (!dl_active) begin
                word_data <= {8'h00, low_byte};
                word_be   <= 2'b01;
            end
        end
    end

    assign dl_wait  = (state == st_busy);
    assign mem.req  = (state == st_busy);
    assign mem.addr = word_addr;
    assign mem.din  = word_data;
    assign mem.be   = word_be;
    assign mem.rnw  = 1'b0;

endmodule

/* list.f */
+incdir+design
design/front_pkg.sv
design/mem_req_if.sv
design/player_input_map.sv
design/dip_switch_bank.sv
design/rom_word_counter.sv
design/rom_write_fsm.sv
design/mem_channel_mux.sv
design/arcade_io_front.sv
bench/front_tb.sv
